/* hdl/stepper_defines.svh */
`ifndef STEPPER_DEFINES_SVH
`define STEPPER_DEFINES_SVH

// peripheral word addresses on the cpu bus
`define ADDR_LEDS          32'h1000_0000
`define ADDR_SPI_OUT_UP    32'h1000_0004
`define ADDR_SPI_OUT_LOW   32'h1000_0008
`define ADDR_SPI_IN_UP     32'h1000_000C
`define ADDR_SPI_IN_LOW    32'h1000_0010
`define ADDR_SPI_CONFIG    32'h1000_0014
`define ADDR_SPI_STATUS    32'h1000_0018
`define ADDR_STEP_CTRL_UP  32'h1000_001C
`define ADDR_STEP_CTRL_LOW 32'h1000_0020
`define ADDR_STEP_STATUS   32'h1000_0024

// bits per spi transfer
`define SPI_FRAME_BITS 40

// one chip select per driver chip
`define SPI_CS_LINES 12

// system clocks per sck half-period
`define SPI_CLK_DIV 4

// clocks high and then low for each step pulse
`define STEP_HALF_PERIOD 4

`endif

/* hdl/bus_pkg.sv */
package bus_pkg;

  // native cpu bus word
  typedef logic [31:0] bus_word_t;

  // one select per mapped register
  typedef enum logic [3:0] {
    SEL_LEDS,
    SEL_SPI_OUT_UP,
    SEL_SPI_OUT_LOW,
    SEL_SPI_IN_UP,
    SEL_SPI_IN_LOW,
    SEL_SPI_CONFIG,
    SEL_SPI_STATUS,
    SEL_STEP_CTRL_UP,
    SEL_STEP_CTRL_LOW,
    SEL_STEP_STATUS,
    // no request or address outside the map
    SEL_NONE
  } reg_sel_e;

endpackage

/* hdl/motion_pkg.sv */
package motion_pkg;

  // spi master sequencing
  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_DONE
  } spi_state_e;

  // step pulse phases
  typedef enum logic [1:0] {
    STEP_IDLE,
    STEP_HIGH,
    STEP_LOW
  } step_state_e;

endpackage

/* hdl/periph_decode.sv */
`include "stepper_defines.svh"

module periph_decode (
  input  logic                mem_valid,
  input  bus_pkg::bus_word_t  mem_addr,
  output bus_pkg::reg_sel_e   sel
);
  import bus_pkg::*;

  // memory map of the peripheral block
  // new peripherals get their address decoded here
  always_comb begin
    sel = SEL_NONE;
    if (mem_valid) begin
      case (mem_addr)
        `ADDR_LEDS: begin
          sel = SEL_LEDS;
        end
        `ADDR_SPI_OUT_UP: begin
          sel = SEL_SPI_OUT_UP;
        end
        `ADDR_SPI_OUT_LOW: begin
          sel = SEL_SPI_OUT_LOW;
        end
        `ADDR_SPI_IN_UP: begin
          sel = SEL_SPI_IN_UP;
        end
        `ADDR_SPI_IN_LOW: begin
          sel = SEL_SPI_IN_LOW;
        end
        `ADDR_SPI_CONFIG: begin
          sel = SEL_SPI_CONFIG;
        end
        `ADDR_SPI_STATUS: begin
          sel = SEL_SPI_STATUS;
        end
        `ADDR_STEP_CTRL_UP: begin
          sel = SEL_STEP_CTRL_UP;
        end
        `ADDR_STEP_CTRL_LOW: begin
          sel = SEL_STEP_CTRL_LOW;
        end
        `ADDR_STEP_STATUS: begin
          sel = SEL_STEP_STATUS;
        end
        default: begin
          sel = SEL_NONE;
        end
      endcase
    end
  end

endmodule

/* hdl/periph_regs.sv */
`include "stepper_defines.svh"

module periph_regs (
  input  logic                        clk_in,
  input  logic                        arst_n,
  input  logic                        mem_valid,
  input  logic [3:0]                  mem_wstrb,
  input  bus_pkg::bus_word_t          mem_wdata,
  input  bus_pkg::reg_sel_e           sel,
  input  logic [`SPI_FRAME_BITS-1:0]  spi_rx_data,
  input  logic                        spi_ready,
  input  logic                        step_done,
  output logic                        mem_ready,
  output bus_pkg::bus_word_t          mem_rdata,
  output logic [3:0]                  led,
  output logic [`SPI_FRAME_BITS-1:0]  spi_tx_data,
  output logic [3:0]                  spi_cs_select,
  output logic                        spi_start,
  output logic [31:0]                 step_count,
  output logic                        step_dir,
  output logic                        step_start
);
  import bus_pkg::*;

  logic      pending_q;
  logic      wr_en;
  bus_word_t leds_q;
  bus_word_t spi_out_up_q;
  bus_word_t spi_out_low_q;
  bus_word_t spi_config_q;
  bus_word_t step_ctrl_up_q;
  bus_word_t step_ctrl_low_q;
  bus_word_t read_word;

  // request seen -> pending -> one ready cycle
  // no new request is taken while ready is high
  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      pending_q <= 1'b0;
      mem_ready <= 1'b0;
    end else begin
      pending_q <= mem_valid && !pending_q && !mem_ready;
      mem_ready <= pending_q;
    end
  end

  // any strobe bit writes the whole word
  assign wr_en = pending_q && (mem_wstrb != 4'b0000);

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      leds_q          <= '0;
      spi_out_up_q    <= '0;
      spi_out_low_q   <= '0;
      spi_config_q    <= '0;
      step_ctrl_up_q  <= '0;
      step_ctrl_low_q <= '0;
    end else if (wr_en) begin
      case (sel)
        SEL_LEDS:          leds_q          <= mem_wdata;
        SEL_SPI_OUT_UP:    spi_out_up_q    <= mem_wdata;
        SEL_SPI_OUT_LOW:   spi_out_low_q   <= mem_wdata;
        SEL_SPI_CONFIG:    spi_config_q    <= mem_wdata;
        SEL_STEP_CTRL_UP:  step_ctrl_up_q  <= mem_wdata;
        SEL_STEP_CTRL_LOW: step_ctrl_low_q <= mem_wdata;
        default: ;
      endcase
    end
  end

  // start strobes line up with the ready cycle
  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      spi_start  <= 1'b0;
      step_start <= 1'b0;
    end else begin
      spi_start  <= wr_en && (sel == SEL_SPI_CONFIG) && mem_wdata[0];
      step_start <= wr_en && (sel == SEL_STEP_CTRL_LOW) && mem_wdata[0];
    end
  end

  always_comb begin
    case (sel)
      SEL_LEDS:          read_word = leds_q;
      SEL_SPI_OUT_UP:    read_word = spi_out_up_q;
      SEL_SPI_OUT_LOW:   read_word = spi_out_low_q;
      // upper rx bits, zero above
      SEL_SPI_IN_UP:
        read_word = {{(64 - `SPI_FRAME_BITS){1'b0}}, spi_rx_data[`SPI_FRAME_BITS-1:32]};
      SEL_SPI_IN_LOW:    read_word = spi_rx_data[31:0];
      SEL_SPI_CONFIG:    read_word = spi_config_q;
      SEL_SPI_STATUS:    read_word = {31'b0, spi_ready};
      SEL_STEP_CTRL_UP:  read_word = step_ctrl_up_q;
      SEL_STEP_CTRL_LOW: read_word = step_ctrl_low_q;
      SEL_STEP_STATUS:   read_word = {31'b0, step_done};
      default:           read_word = '0;
    endcase
  end

  // bus data only during the ready cycle
  assign mem_rdata = mem_ready ? read_word : '0;

  // field mapping to the peripherals
  assign led           = leds_q[3:0];
  assign spi_tx_data   = {spi_out_up_q[`SPI_FRAME_BITS-33:0], spi_out_low_q};
  assign spi_cs_select = spi_config_q[4:1];
  assign step_count    = step_ctrl_up_q;
  assign step_dir      = step_ctrl_low_q[1];

endmodule

/* hdl/spi_master.sv */
`include "stepper_defines.svh"

module spi_master (
  input  logic                        clk_in,
  input  logic                        arst_n,
  input  logic [`SPI_FRAME_BITS-1:0]  tx_data,
  input  logic [3:0]                  cs_select,
  input  logic                        start,
  input  logic                        miso,
  output logic                        sck,
  output logic                        mosi,
  output logic [`SPI_CS_LINES-1:0]    cs_n,
  output logic [`SPI_FRAME_BITS-1:0]  rx_data,
  output logic                        ready
);
  import motion_pkg::*;

  localparam int DIV_W = $clog2(`SPI_CLK_DIV + 1);
  localparam int BIT_W = $clog2(`SPI_FRAME_BITS);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_CLK_DIV - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`SPI_FRAME_BITS - 1);

  spi_state_e                  state_q;
  logic [DIV_W-1:0]            div_cnt_q;
  logic [BIT_W-1:0]            bit_cnt_q;
  logic [`SPI_FRAME_BITS-1:0]  tx_shift_q;
  logic [`SPI_FRAME_BITS-1:0]  rx_shift_q;
  logic [`SPI_CS_LINES-1:0]    cs_n_sel;
  logic                        launch;
  logic                        sck_tick;

  // one-hot low select where out of range selects nothing
  always_comb begin
    for (int i = 0; i < `SPI_CS_LINES; i++) begin
      cs_n_sel[i] = (cs_select != 4'(i));
    end
  end

  assign launch   = (state_q == SPI_IDLE) && start;
  // end of an sck half-period
  assign sck_tick = (state_q == SPI_SHIFT) && (div_cnt_q == DIV_LAST);

  // msb first with the line idling low
  assign mosi = (state_q == SPI_SHIFT) && tx_shift_q[`SPI_FRAME_BITS-1];

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= SPI_IDLE;
      div_cnt_q <= '0;
      bit_cnt_q <= '0;
      sck       <= 1'b0;
      cs_n      <= '1;
      ready     <= 1'b1;
      rx_data   <= '0;
    end else begin
      case (state_q)
        SPI_IDLE: begin
          if (start) begin
            state_q   <= SPI_SHIFT;
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
            cs_n      <= cs_n_sel;
            ready     <= 1'b0;
          end
        end
        SPI_SHIFT: begin
          if (sck_tick) begin
            div_cnt_q <= '0;
            sck       <= !sck;
            // falling sck closes one bit
            if (sck) begin
              if (bit_cnt_q == BIT_LAST) begin
                state_q <= SPI_DONE;
              end else begin
                bit_cnt_q <= bit_cnt_q + BIT_W'(1);
              end
            end
          end else begin
            div_cnt_q <= div_cnt_q + DIV_W'(1);
          end
        end
        SPI_DONE: begin
          cs_n    <= '1;
          ready   <= 1'b1;
          rx_data <= rx_shift_q;
          state_q <= SPI_IDLE;
        end
        default: begin
          state_q <= SPI_IDLE;
        end
      endcase
    end
  end

  // shift registers
  // mosi moves on falling sck and miso is taken on rising sck
  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      tx_shift_q <= '0;
      rx_shift_q <= '0;
    end else if (launch) begin
      tx_shift_q <= tx_data;
    end else if (sck_tick) begin
      if (sck) begin
        tx_shift_q <= {tx_shift_q[`SPI_FRAME_BITS-2:0], 1'b0};
      end else begin
        rx_shift_q <= {rx_shift_q[`SPI_FRAME_BITS-2:0], miso};
      end
    end
  end

endmodule

/* hdl/step_generator.sv */
`include "stepper_defines.svh"

module step_generator (
  input  logic        clk_in,
  input  logic        arst_n,
  input  logic        start,
  input  logic [31:0] count,
  input  logic        dir_in,
  output logic        step,
  output logic        dir,
  output logic        done
);
  import motion_pkg::*;

  localparam int TMR_W = $clog2(`STEP_HALF_PERIOD + 1);
  localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(`STEP_HALF_PERIOD - 1);

  step_state_e       state_q;
  logic [TMR_W-1:0]  timer_q;
  logic [31:0]       remaining_q;
  logic              phase_end;

  assign phase_end = (timer_q == TMR_LAST);

  // a move starts in the low phase with the timer expired
  // so the first pulse follows one clock after start
  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      state_q     <= STEP_IDLE;
      timer_q     <= '0;
      remaining_q <= '0;
      step        <= 1'b0;
      dir         <= 1'b0;
      done        <= 1'b1;
    end else begin
      case (state_q)
        STEP_IDLE: begin
          // starts while busy never reach this branch
          if (start) begin
            state_q     <= STEP_LOW;
            timer_q     <= TMR_LAST;
            remaining_q <= count;
            dir         <= dir_in;
            done        <= 1'b0;
          end
        end
        STEP_HIGH: begin
          if (phase_end) begin
            state_q <= STEP_LOW;
            timer_q <= '0;
            step    <= 1'b0;
          end else begin
            timer_q <= timer_q + TMR_W'(1);
          end
        end
        STEP_LOW: begin
          if (!phase_end) begin
            timer_q <= timer_q + TMR_W'(1);
          end else if (remaining_q == 32'd0) begin
            // last low phase over
            state_q <= STEP_IDLE;
            done    <= 1'b1;
          end else begin
            state_q     <= STEP_HIGH;
            timer_q     <= '0;
            remaining_q <= remaining_q - 32'd1;
            step        <= 1'b1;
          end
        end
        default: begin
          state_q <= STEP_IDLE;
        end
      endcase
    end
  end

endmodule

/* hdl/stepper_periph.sv */
`include "stepper_defines.svh"

module stepper_periph (
  input  logic                      clk_in,
  input  logic                      arst_n,
  input  logic                      mem_valid,
  input  bus_pkg::bus_word_t        mem_addr,
  input  bus_pkg::bus_word_t        mem_wdata,
  input  logic [3:0]                mem_wstrb,
  input  logic                      miso,
  output logic                      mem_ready,
  output bus_pkg::bus_word_t        mem_rdata,
  output logic [3:0]                led,
  output logic                      sck,
  output logic                      mosi,
  output logic [`SPI_CS_LINES-1:0]  cs_n,
  output logic                      step,
  output logic                      dir
);
  import bus_pkg::*;

  reg_sel_e                    sel;
  logic [`SPI_FRAME_BITS-1:0]  spi_tx_data;
  logic [`SPI_FRAME_BITS-1:0]  spi_rx_data;
  logic [3:0]                  spi_cs_select;
  logic                        spi_start;
  logic                        spi_ready;
  logic [31:0]                 step_count;
  logic                        step_dir;
  logic                        step_start;
  logic                        step_done;

  periph_decode decode0 (
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .sel       (sel)
  );

  periph_regs regs0 (
    .clk_in        (clk_in),
    .arst_n        (arst_n),
    .mem_valid     (mem_valid),
    .mem_wstrb     (mem_wstrb),
    .mem_wdata     (mem_wdata),
    .sel           (sel),
    .spi_rx_data   (spi_rx_data),
    .spi_ready     (spi_ready),
    .step_done     (step_done),
    .mem_ready     (mem_ready),
    .mem_rdata     (mem_rdata),
    .led           (led),
    .spi_tx_data   (spi_tx_data),
    .spi_cs_select (spi_cs_select),
    .spi_start     (spi_start),
    .step_count    (step_count),
    .step_dir      (step_dir),
    .step_start    (step_start)
  );

  // driver chip link
  spi_master spi0 (
    .clk_in    (clk_in),
    .arst_n    (arst_n),
    .tx_data   (spi_tx_data),
    .cs_select (spi_cs_select),
    .start     (spi_start),
    .miso      (miso),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .rx_data   (spi_rx_data),
    .ready     (spi_ready)
  );

  step_generator step0 (
    .clk_in (clk_in),
    .arst_n (arst_n),
    .start  (step_start),
    .count  (step_count),
    .dir_in (step_dir),
    .step   (step),
    .dir    (dir),
    .done   (step_done)
  );

endmodule

/* sim/stepper_tb.sv */
`include "stepper_defines.svh"

module stepper_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 100;
  localparam int STEP_MOVES = 6;
  // upper bound of all step counts written including restarts
  localparam int STEPS_MAX = STEP_MOVES * 20 + 20 + 27;
  localparam int WATCHDOG_CYCLES = 2000 + 3 * 330 + STEPS_MAX * 8;

  logic                        clk_in = 1'b0;
  logic                        arst_n;
  logic                        mem_valid;
  logic [31:0]                 mem_addr;
  logic [31:0]                 mem_wdata;
  logic [3:0]                  mem_wstrb;
  logic                        miso;
  logic                        mem_ready;
  logic [31:0]                 mem_rdata;
  logic [3:0]                  led;
  logic                        sck;
  logic                        mosi;
  logic [`SPI_CS_LINES-1:0]    cs_n;
  logic                        step;
  logic                        dir;

  logic [31:0]                 lfsr_q = 32'd73;
  // spi slave model
  logic [`SPI_FRAME_BITS-1:0]  resp_word = '0;
  logic [`SPI_FRAME_BITS-1:0]  mosi_cap = '0;
  logic [`SPI_CS_LINES-1:0]    exp_cs = '1;
  logic [5:0]                  miso_idx;
  int                          sck_rises = 0;
  int                          sck_falls = 0;
  int                          fall_base = 0;
  int                          spi_rise_base = 0;
  // step pulse monitor
  logic                        step_prev = 1'b0;
  int                          run_len = 0;
  int                          step_rises = 0;
  int                          rise_base = 0;

  stepper_periph dut0 (
    .clk_in    (clk_in),
    .arst_n    (arst_n),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .miso      (miso),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .led       (led),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .step      (step),
    .dir       (dir)
  );

  always #(CLK_PERIOD / 2) clk_in = ~clk_in;

  task automatic stop_failed();
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic value_error(input string test, input logic [63:0] exp, input logic [63:0] act);
    $display("** Error %s expected %0h actual %0h", test, exp, act);
    stop_failed();
  endtask

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  // ready is a single pulse
  assert property (@(posedge clk_in) disable iff (!arst_n) !(mem_ready && $past(mem_ready)))
    else value_error("ready pulse width", 64'd1, 64'd2);

  // slave drives the next response bit after each falling sck
  always_comb begin
    miso_idx = 6'(`SPI_FRAME_BITS - 1 - ((sck_falls - fall_base) % `SPI_FRAME_BITS));
  end
  assign miso = resp_word[miso_idx];

  always @(posedge sck) begin
    mosi_cap  <= {mosi_cap[`SPI_FRAME_BITS-2:0], mosi};
    sck_rises <= sck_rises + 1;
    assert (cs_n == exp_cs) else value_error("spi chip select", 64'(exp_cs), 64'(cs_n));
  end

  always @(negedge sck) begin
    sck_falls <= sck_falls + 1;
  end

  // phase lengths of the step line
  // low phase checked only between pulses of one move
  always @(posedge clk_in) begin
    if (step != step_prev) begin
      if (step) begin
        if (step_rises != rise_base) begin
          assert (run_len == `STEP_HALF_PERIOD)
            else value_error("step low phase", 64'(`STEP_HALF_PERIOD), 64'(run_len));
        end
        step_rises <= step_rises + 1;
      end else begin
        assert (run_len == `STEP_HALF_PERIOD)
          else value_error("step high phase", 64'(`STEP_HALF_PERIOD), 64'(run_len));
      end
      run_len   <= 1;
      step_prev <= step;
    end else begin
      run_len <= run_len + 1;
    end
  end

  task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb, output logic [31:0] rdata);
    int edges;
    @(negedge clk_in);
    mem_addr  = addr;
    mem_wdata = wdata;
    mem_wstrb = wstrb;
    mem_valid = 1'b1;
    edges = 0;
    do begin
      @(posedge clk_in);
      edges++;
      @(negedge clk_in);
    end while (!mem_ready);
    rdata     = mem_rdata;
    mem_valid = 1'b0;
    mem_wstrb = 4'd0;
    assert (edges == 2) else value_error("ready latency", 64'd2, 64'(edges));
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_xfer(addr, data, 4'hF, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_xfer(addr, 32'd0, 4'd0, data);
  endtask

  task automatic check_read(input string name, input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    bus_read(addr, rd);
    assert (rd == exp) else value_error(name, 64'(exp), 64'(rd));
  endtask

  task automatic readback_check(input string name, input logic [31:0] addr,
                                input logic [31:0] mask);
    logic [31:0] w;
    w = 32'(rand_bits(32)) & mask;
    bus_write(addr, w);
    check_read(name, addr, w);
  endtask

  task automatic test_reset();
    assert (mem_ready == 1'b0) else value_error("reset mem_ready", 64'd0, 64'(mem_ready));
    assert (cs_n == '1) else value_error("reset cs_n", 64'hFFF, 64'(cs_n));
    assert (sck == 1'b0) else value_error("reset sck", 64'd0, 64'(sck));
    assert (step == 1'b0) else value_error("reset step", 64'd0, 64'(step));
    assert (led == 4'd0) else value_error("reset led", 64'd0, 64'(led));
    check_read("reset spi status", `ADDR_SPI_STATUS, 32'd1);
    check_read("reset step status", `ADDR_STEP_STATUS, 32'd1);
  endtask

  task automatic test_readback();
    logic [31:0] w;
    for (int round = 0; round < 2; round++) begin
      w = 32'(rand_bits(32));
      bus_write(`ADDR_LEDS, w);
      check_read("led readback", `ADDR_LEDS, w);
      assert (led == w[3:0]) else value_error("led pins", 64'(w[3:0]), 64'(led));
      readback_check("spi out upper", `ADDR_SPI_OUT_UP, 32'hFFFF_FFFF);
      readback_check("spi out lower", `ADDR_SPI_OUT_LOW, 32'hFFFF_FFFF);
      // bit 0 kept clear so nothing starts
      readback_check("spi config", `ADDR_SPI_CONFIG, 32'hFFFF_FFFE);
      readback_check("step ctrl upper", `ADDR_STEP_CTRL_UP, 32'hFFFF_FFFF);
      readback_check("step ctrl lower", `ADDR_STEP_CTRL_LOW, 32'hFFFF_FFFE);
    end
    bus_write(32'h1000_0028, 32'hFFFF_FFFF);
    check_read("unmapped read", 32'h1000_0028, 32'd0);
  endtask

  task automatic spi_launch(input logic [3:0] cs, output logic [`SPI_FRAME_BITS-1:0] tx);
    logic [31:0] up;
    logic [31:0] low;
    up  = 32'(rand_bits(32));
    low = 32'(rand_bits(32));
    tx  = {up[7:0], low};
    resp_word = `SPI_FRAME_BITS'(rand_bits(`SPI_FRAME_BITS));
    exp_cs = (int'(cs) < `SPI_CS_LINES) ? ~(`SPI_CS_LINES'(1) << cs) : '1;
    fall_base     = sck_falls;
    spi_rise_base = sck_rises;
    bus_write(`ADDR_SPI_OUT_UP, up);
    bus_write(`ADDR_SPI_OUT_LOW, low);
    bus_write(`ADDR_SPI_CONFIG, {27'd0, cs, 1'b1});
    check_read("spi status busy", `ADDR_SPI_STATUS, 32'd0);
  endtask

  task automatic spi_finish(input logic [`SPI_FRAME_BITS-1:0] tx);
    logic [31:0] rd;
    do begin
      bus_read(`ADDR_SPI_STATUS, rd);
    end while (rd[0] == 1'b0);
    assert (rd == 32'd1) else value_error("spi status done", 64'd1, 64'(rd));
    assert (sck_rises - spi_rise_base == `SPI_FRAME_BITS)
      else value_error("spi clock count", 64'(`SPI_FRAME_BITS), 64'(sck_rises - spi_rise_base));
    assert (mosi_cap == tx) else value_error("spi mosi frame", 64'(tx), 64'(mosi_cap));
    assert (cs_n == '1) else value_error("spi cs_n after frame", 64'hFFF, 64'(cs_n));
    check_read("spi in upper", `ADDR_SPI_IN_UP, {24'd0, resp_word[`SPI_FRAME_BITS-1:32]});
    check_read("spi in lower", `ADDR_SPI_IN_LOW, resp_word[31:0]);
  endtask

  task automatic step_launch(input logic [31:0] count, input logic d);
    rise_base = step_rises;
    bus_write(`ADDR_STEP_CTRL_UP, count);
    bus_write(`ADDR_STEP_CTRL_LOW, {30'd0, d, 1'b1});
    if (count != 32'd0) begin
      check_read("step status busy", `ADDR_STEP_STATUS, 32'd0);
    end
  endtask

  task automatic step_finish(input logic [31:0] count, input logic d);
    logic [31:0] rd;
    do begin
      bus_read(`ADDR_STEP_STATUS, rd);
    end while (rd[0] == 1'b0);
    assert (step_rises - rise_base == int'(count))
      else value_error("step pulse count", 64'(count), 64'(step_rises - rise_base));
    assert (dir == d) else value_error("step direction", 64'(d), 64'(dir));
    assert (step == 1'b0) else value_error("step idle level", 64'd0, 64'(step));
  endtask

  task automatic test_steps();
    logic [31:0] count;
    logic        d;
    for (int i = 0; i < STEP_MOVES; i++) begin
      // first move covers the zero count
      count = (i == 0) ? 32'd0 : 32'(rand_bits(5) % 21);
      d = 1'(rand_bits(1));
      step_launch(count, d);
      step_finish(count, d);
    end
  endtask

  task automatic test_overlap();
    logic [`SPI_FRAME_BITS-1:0] tx;
    logic [31:0]                count;
    logic [3:0]                 cs;
    logic                       d;
    cs    = 4'(rand_bits(4) % 12);
    count = 32'(rand_bits(4) % 11 + 10);
    d     = 1'(rand_bits(1));
    spi_launch(cs, tx);
    step_launch(count, d);
    // restarts while both are busy
    bus_write(`ADDR_STEP_CTRL_UP, count + 32'd7);
    bus_write(`ADDR_STEP_CTRL_LOW, {30'd0, !d, 1'b1});
    bus_write(`ADDR_SPI_OUT_LOW, ~tx[31:0]);
    bus_write(`ADDR_SPI_CONFIG, {27'd0, 4'((cs + 4'd1) % 4'd12), 1'b1});
    step_finish(count, d);
    spi_finish(tx);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    stop_failed();
  end

  initial begin
    logic [`SPI_FRAME_BITS-1:0] tx;
    arst_n    = 1'b0;
    mem_valid = 1'b0;
    mem_addr  = 32'd0;
    mem_wdata = 32'd0;
    mem_wstrb = 4'd0;
    repeat (4) @(negedge clk_in);
    arst_n = 1'b1;
    test_reset();
    test_readback();
    spi_launch(4'(rand_bits(4) % 12), tx);
    spi_finish(tx);
    // select beyond the last driver chip
    spi_launch(4'(12 + rand_bits(2)), tx);
    spi_finish(tx);
    test_steps();
    test_overlap();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+hdl
hdl/bus_pkg.sv
hdl/motion_pkg.sv
hdl/periph_decode.sv
hdl/periph_regs.sv
hdl/spi_master.sv
hdl/step_generator.sv
hdl/stepper_periph.sv
sim/stepper_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the stepper peripheral testbench with verilator and run it
# exit status is non-zero when the build or the simulation fails

cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
  -f verilog.f \
  --top-module stepper_tb \
  --Mdir obj_dir \
  -o stepper_sim &&
./obj_dir/stepper_sim &&
echo "simulation finished without errors" ||
{ echo "simulation run reported an error" >&2; exit 1; }
